/* project.f */
rtl/core_pkg.sv
rtl/register_file.sv
rtl/id_decoder.sv
rtl/issue_queue.sv
rtl/alu_exec.sv
rtl/decode_core_top.sv
tests/tb_clock_gen.sv
tests/decode_core_properties.sv
tests/tb_decode_core.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_decode_core
FILELIST  := project.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Done: errors found
PASS_MSG  := Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "TEST FAILED: run incomplete"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/tb_decode_core.sv */
// Testbench top for the issue path, table driven with random input gaps and output stalls
`default_nettype none

module tb_decode_core
  import core_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_ROWS       = 25;
  localparam int TIMEOUT_CYCLES = 40 * NUM_ROWS;
  localparam int RESET_CYCLES   = 4;
  localparam int SEED           = 19;
  // Sample point after the falling edge, well before the next rising edge
  localparam int SETTLE_NS      = 10;

  // One instruction and the result it should produce
  typedef struct packed {
    logic [XLEN-1:0] instr;
    result_t         expected;
  } row_t;

  logic            clk;
  logic            rst_n;
  logic            instr_valid_i;
  logic [XLEN-1:0] instr_i;
  logic            instr_ready_o;
  logic            res_valid_o;
  result_t         res_o;
  logic            res_ready_i;

  row_t rows [NUM_ROWS];
  int   row_count    = 0;
  int   results_seen = 0;
  int   cycle_count  = 0;
  int   seed_draw;
  logic run_started  = 1'b0;
  // Idle cycles before each row and per-cycle output ready
  int   gap_len [NUM_ROWS];
  logic ready_draw [TIMEOUT_CYCLES];

  tb_clock_gen u_clk_gen (
    .clk_o (clk)
  );

  decode_core_top uut (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .instr_ready_o (instr_ready_o),
    .res_valid_o   (res_valid_o),
    .res_o         (res_o),
    .res_ready_i   (res_ready_i)
  );

  ////////////////////////////////////////////////////////////////////////////
  // RV32I encoders and the stimulus table
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] encode_i_type(input logic [2:0] funct3, input logic [4:0] rd,
                                                input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, funct3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] encode_r_type(input logic [6:0] funct7, input logic [2:0] funct3,
                                                input logic [4:0] rd, input logic [4:0] rs1,
                                                input logic [4:0] rs2);
    return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] encode_u_type(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  task automatic add_row(input logic [31:0] instr, input logic [4:0] rd,
                         input logic [31:0] value, input logic illegal);
    rows[row_count].instr            = instr;
    rows[row_count].expected.rd      = rd;
    rows[row_count].expected.value   = value;
    rows[row_count].expected.illegal = illegal;
    row_count++;
  endtask

  task automatic load_table();
    // Immediate group, x1 = 5 and x2 = -3 feed the rest
    add_row(encode_i_type(3'b000, 5'd1, 5'd0, 12'd5), 5'd1, 32'h0000_0005, 1'b0);
    add_row(encode_i_type(3'b000, 5'd2, 5'd0, 12'hFFD), 5'd2, 32'hFFFF_FFFD, 1'b0);
    add_row(encode_i_type(3'b010, 5'd3, 5'd2, 12'hFFE), 5'd3, 32'h0000_0001, 1'b0);
    add_row(encode_i_type(3'b011, 5'd4, 5'd2, 12'd5), 5'd4, 32'h0000_0000, 1'b0);
    add_row(encode_i_type(3'b100, 5'd5, 5'd1, 12'h0F0), 5'd5, 32'h0000_00F5, 1'b0);
    add_row(encode_i_type(3'b110, 5'd6, 5'd1, 12'h700), 5'd6, 32'h0000_0705, 1'b0);
    add_row(encode_i_type(3'b111, 5'd7, 5'd5, 12'h00F), 5'd7, 32'h0000_0005, 1'b0);
    // Immediate shifts, SRAI carries 0100000 in the upper bits
    add_row(encode_i_type(3'b001, 5'd8, 5'd1, 12'h004), 5'd8, 32'h0000_0050, 1'b0);
    add_row(encode_i_type(3'b101, 5'd9, 5'd2, 12'h01C), 5'd9, 32'h0000_000F, 1'b0);
    add_row(encode_i_type(3'b101, 5'd10, 5'd2, 12'h401), 5'd10, 32'hFFFF_FFFE, 1'b0);
    add_row(encode_u_type(5'd11, 20'h12345), 5'd11, 32'h1234_5000, 1'b0);
    // Register group, each reads results just written
    add_row(encode_r_type(7'h00, 3'b000, 5'd12, 5'd11, 5'd1), 5'd12, 32'h1234_5005, 1'b0);
    add_row(encode_r_type(7'h20, 3'b000, 5'd13, 5'd12, 5'd6), 5'd13, 32'h1234_4900, 1'b0);
    // Shift by 0x50 keeps only 16
    add_row(encode_r_type(7'h00, 3'b001, 5'd14, 5'd1, 5'd8), 5'd14, 32'h0005_0000, 1'b0);
    add_row(encode_r_type(7'h00, 3'b010, 5'd15, 5'd2, 5'd1), 5'd15, 32'h0000_0001, 1'b0);
    add_row(encode_r_type(7'h00, 3'b011, 5'd16, 5'd2, 5'd1), 5'd16, 32'h0000_0000, 1'b0);
    add_row(encode_r_type(7'h00, 3'b100, 5'd17, 5'd13, 5'd11), 5'd17, 32'h0000_1900, 1'b0);
    add_row(encode_r_type(7'h00, 3'b101, 5'd18, 5'd2, 5'd1), 5'd18, 32'h07FF_FFFF, 1'b0);
    add_row(encode_r_type(7'h20, 3'b101, 5'd19, 5'd2, 5'd1), 5'd19, 32'hFFFF_FFFF, 1'b0);
    add_row(encode_r_type(7'h00, 3'b110, 5'd20, 5'd17, 5'd14), 5'd20, 32'h0005_1900, 1'b0);
    add_row(encode_r_type(7'h00, 3'b111, 5'd21, 5'd20, 5'd6), 5'd21, 32'h0000_0100, 1'b0);
    // Write to x0 still reports 105, later read of x0 is zero
    add_row(encode_i_type(3'b000, 5'd0, 5'd1, 12'd100), 5'd0, 32'h0000_0069, 1'b0);
    add_row(encode_r_type(7'h00, 3'b000, 5'd22, 5'd0, 5'd1), 5'd22, 32'h0000_0005, 1'b0);
    // Store opcode naming x1, then x1 must still hold 5
    add_row(32'h0000_00A3, 5'd1, 32'h0000_0000, 1'b1);
    add_row(encode_i_type(3'b000, 5'd23, 5'd1, 12'd0), 5'd23, 32'h0000_0005, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Failure reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_on_failure(input string reason);
    $display("%s", reason);
    $display("Done: errors found");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
      stop_on_failure($sformatf("[ERROR] time=%0t %s: got 0x%08h, expected 0x%08h",
                                $time, name, actual, expected));
  endtask

  // Hang guard
  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
      stop_on_failure($sformatf("Timeout after %0d cycles with %0d of %0d results seen",
                                cycle_count, results_seen, NUM_ROWS));
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reset, sequencing and end of run
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    seed_draw     = $urandom(SEED);
    rst_n         = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    res_ready_i   = 1'b0;
    load_table();
    // Whole random stream drawn here, one seeded process
    for (int i = 0; i < NUM_ROWS; i++)
    begin
      gap_len[i] = int'($urandom % 3);
    end
    for (int i = 0; i < TIMEOUT_CYCLES; i++)
    begin
      ready_draw[i] = (($urandom % 4) != 0);
    end
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #(SETTLE_NS);
    // Empty output, room to accept
    check_value("res_valid_o", 32'(res_valid_o), 32'd0);
    check_value("instr_ready_o", 32'(instr_ready_o), 32'd1);
    run_started = 1'b1;
    wait (results_seen == NUM_ROWS);
    // Nothing left over after the last row
    repeat (4)
    begin
      @(negedge clk);
      #(SETTLE_NS);
      check_value("res_valid_o", 32'(res_valid_o), 32'd0);
    end
    $display("Done: no errors");
    $finish;
  end

  // Driver, rows in order with random idle gaps
  initial
  begin : drive_rows
    wait (run_started);
    for (int idx = 0; idx < NUM_ROWS; idx++)
    begin
      repeat (gap_len[idx])
      begin
        @(negedge clk);
        instr_valid_i = 1'b0;
      end
      @(negedge clk);
      instr_valid_i = 1'b1;
      instr_i       = rows[idx].instr;
      // Held until ready, taken on the next rising edge
      #(SETTLE_NS);
      while (!instr_ready_o)
      begin
        @(negedge clk);
        #(SETTLE_NS);
      end
    end
    @(negedge clk);
    instr_valid_i = 1'b0;
  end

  // Checker, random output stalls, results compared in table order
  initial
  begin : check_results
    int draw_idx;
    draw_idx = 0;
    wait (run_started);
    while (results_seen < NUM_ROWS)
    begin
      @(negedge clk);
      res_ready_i = ready_draw[draw_idx % TIMEOUT_CYCLES];
      draw_idx++;
      #(SETTLE_NS);
      if (res_valid_o && res_ready_i)
      begin
        check_value("res_o.rd", 32'(res_o.rd), 32'(rows[results_seen].expected.rd));
        check_value("res_o.value", res_o.value, rows[results_seen].expected.value);
        check_value("res_o.illegal", 32'(res_o.illegal),
                    32'(rows[results_seen].expected.illegal));
        results_seen++;
      end
    end
  end

endmodule

`default_nettype wire

/* tests/decode_core_properties.sv */
// Concurrent checks on reset behavior, output hold under stall and input ready
`default_nettype none

module decode_core_properties
  import core_pkg::*;
(
  input logic    clk,
  input logic    rst_n,
  input logic    instr_ready_o,
  input logic    res_valid_o,
  input result_t res_o,
  input logic    res_ready_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // Output slot empty while reset is held
  a_reset_quiet : assert property (@(posedge clk) !rst_n |-> !res_valid_o)
    else $error("res_valid_o high while rst_n is low");

  // Stalled result keeps its payload
  a_res_hold : assert property (@(posedge clk) disable iff (!rst_n)
    (res_valid_o && !res_ready_i) |=> $stable(res_o))
    else $error("res_o changed while stalled");

  // Ready always resolved once out of reset
  a_ready_known : assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(instr_ready_o))
    else $error("instr_ready_o unknown after reset");

endmodule

bind decode_core_top decode_core_properties u_properties (
  .clk           (clk),
  .rst_n         (rst_n),
  .instr_ready_o (instr_ready_o),
  .res_valid_o   (res_valid_o),
  .res_o         (res_o),
  .res_ready_i   (res_ready_i)
);

`default_nettype wire

/* tests/tb_clock_gen.sv */
// Testbench clock generator, free running with a 100 ns period
`default_nettype none

module tb_clock_gen (
  output logic clk_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 100;

  // Starts low, first rising edge at half a period
  initial clk_o = 1'b0;

  always #(CLK_PERIOD / 2) clk_o = ~clk_o;

endmodule

`default_nettype wire

/* rtl/decode_core_top.sv */
// Issue path top level connecting decoder, register file, issue queue and ALU
`default_nettype none

module decode_core_top
  import core_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            instr_valid_i,
  input  logic [XLEN-1:0] instr_i,
  output logic            instr_ready_o,
  output logic            res_valid_o,
  output result_t         res_o,
  input  logic            res_ready_i
);

  // Register file read ports
  logic [REG_ADDR_W-1:0] raddr_a;
  logic [REG_ADDR_W-1:0] raddr_b;
  logic [XLEN-1:0]       rdata_a;
  logic [XLEN-1:0]       rdata_b;
  // Decoder to queue, credit based
  logic                  push;
  issue_pkt_t            pkt;
  logic                  credit;
  // Queue to ALU
  logic                  q_valid;
  issue_pkt_t            q_pkt;
  logic                  pop;
  // ALU write-back, also scoreboard clear
  wb_t                   wb;

  id_decoder u_id_decoder (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .instr_ready_o (instr_ready_o),
    .raddr_a_o     (raddr_a),
    .raddr_b_o     (raddr_b),
    .rdata_a_i     (rdata_a),
    .rdata_b_i     (rdata_b),
    .wb_i          (wb),
    .credit_i      (credit),
    .push_o        (push),
    .pkt_o         (pkt)
  );

  register_file u_register_file (
    .clk       (clk),
    .rst_n     (rst_n),
    .raddr_a_i (raddr_a),
    .raddr_b_i (raddr_b),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .wb_i      (wb)
  );

  issue_queue u_issue_queue (
    .clk       (clk),
    .rst_n     (rst_n),
    .push_i    (push),
    .pkt_i     (pkt),
    .q_valid_o (q_valid),
    .q_pkt_o   (q_pkt),
    .pop_i     (pop),
    .credit_o  (credit)
  );

  alu_exec u_alu_exec (
    .clk         (clk),
    .rst_n       (rst_n),
    .q_valid_i   (q_valid),
    .q_pkt_i     (q_pkt),
    .pop_o       (pop),
    .wb_o        (wb),
    .res_valid_o (res_valid_o),
    .res_o       (res_o),
    .res_ready_i (res_ready_i)
  );

endmodule

`default_nettype wire

/* rtl/alu_exec.sv */
// ALU execute unit with result register, register write-back and valid/ready output
`default_nettype none

module alu_exec
  import core_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       q_valid_i,
  input  issue_pkt_t q_pkt_i,
  output logic       pop_o,
  output wb_t        wb_o,
  output logic       res_valid_o,
  output result_t    res_o,
  input  logic       res_ready_i
);

  logic [XLEN-1:0]         op_a;
  logic [XLEN-1:0]         op_b;
  logic [$clog2(XLEN)-1:0] shamt;
  logic [XLEN-1:0]         alu_result;
  result_t                 res_q;
  logic                    res_valid_q;

  assign op_a  = q_pkt_i.operand_a;
  assign op_b  = q_pkt_i.operand_b;
  // Low five bits only
  assign shamt = op_b[$clog2(XLEN)-1:0];

  always_comb
  begin
    case (q_pkt_i.alu_op)
      ALU_ADD:    alu_result = op_a + op_b;
      ALU_SUB:    alu_result = op_a - op_b;
      ALU_SLL:    alu_result = op_a << shamt;
      ALU_SLT:    alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   alu_result = {{(XLEN-1){1'b0}}, op_a < op_b};
      ALU_XOR:    alu_result = op_a ^ op_b;
      ALU_SRL:    alu_result = op_a >> shamt;
      ALU_SRA:    alu_result = $unsigned($signed(op_a) >>> shamt);
      ALU_OR:     alu_result = op_a | op_b;
      ALU_AND:    alu_result = op_a & op_b;
      ALU_PASS_B: alu_result = op_b;
      default:    alu_result = '0;
    endcase
  end

  // Take the next op when the output slot is free or draining now
  assign pop_o = q_valid_i && (!res_valid_q || res_ready_i);

  // Register write on the pop edge, x0 and illegal ops excluded
  assign wb_o.we   = pop_o && q_pkt_i.we && (q_pkt_i.rd != '0);
  assign wb_o.addr = q_pkt_i.rd;
  assign wb_o.data = alu_result;

  // Output valid
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      res_valid_q <= 1'b0;
    else if (pop_o)
      res_valid_q <= 1'b1;
    else if (res_ready_i)
      res_valid_q <= 1'b0;
  end

  // Output payload, held while stalled
  always_ff @(posedge clk)
  begin
    if (pop_o)
    begin
      res_q.rd      <= q_pkt_i.rd;
      res_q.value   <= q_pkt_i.illegal ? '0 : alu_result;
      res_q.illegal <= q_pkt_i.illegal;
    end
  end

  assign res_valid_o = res_valid_q;
  assign res_o       = res_q;

endmodule

`default_nettype wire

/* rtl/issue_queue.sv */
// Circular FIFO of issue packets, returns one credit pulse for every entry popped
`default_nettype none

module issue_queue
  import core_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       push_i,
  input  issue_pkt_t pkt_i,
  output logic       q_valid_o,
  output issue_pkt_t q_pkt_o,
  input  logic       pop_i,
  output logic       credit_o
);

  // Packet storage
  issue_pkt_t mem_q [QUEUE_DEPTH];

  logic [QUEUE_PTR_W-1:0] wr_ptr_q;
  logic [QUEUE_PTR_W-1:0] rd_ptr_q;
  // Occupancy, 0..QUEUE_DEPTH
  logic [CREDIT_W-1:0]    count_q;
  logic                   credit_q;

  // Producer holds credits, so a push never meets a full queue
  always_ff @(posedge clk)
  begin
    if (push_i)
      mem_q[wr_ptr_q] <= pkt_i;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end
    else
    begin
      if (push_i)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop_i)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      // Count moves only when one side acts alone
      if (push_i && !pop_i)
        count_q <= count_q + 1'b1;
      else if (!push_i && pop_i)
        count_q <= count_q - 1'b1;
      // Freed slot goes back one cycle after the pop
      credit_q <= pop_i;
    end
  end

  assign q_valid_o = (count_q != '0);
  assign q_pkt_o   = mem_q[rd_ptr_q];
  assign credit_o  = credit_q;

endmodule

`default_nettype wire

/* rtl/id_decoder.sv */
// Instruction decoder with immediates, operand muxing, scoreboard and queue credit counter
`default_nettype none

module id_decoder
  import core_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  instr_valid_i,
  input  logic [XLEN-1:0]       instr_i,
  output logic                  instr_ready_o,
  output logic [REG_ADDR_W-1:0] raddr_a_o,
  output logic [REG_ADDR_W-1:0] raddr_b_o,
  input  logic [XLEN-1:0]       rdata_a_i,
  input  logic [XLEN-1:0]       rdata_b_i,
  input  wb_t                   wb_i,
  input  logic                  credit_i,
  output logic                  push_o,
  output issue_pkt_t            pkt_o
);

  // Instruction fields
  opcode_e               opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [REG_ADDR_W-1:0] rd;
  // Immediates
  logic [XLEN-1:0]       imm_i_type;
  logic [XLEN-1:0]       imm_shamt;
  logic [XLEN-1:0]       imm_u_type;
  logic [XLEN-1:0]       imm_b;
  // Decode results
  alu_op_e               alu_op;
  logic                  use_imm;
  logic                  uses_rs1;
  logic                  uses_rs2;
  logic                  illegal;
  // Scoreboard and flow control
  logic [NUM_REGS-1:0]   pending_q;
  logic [CREDIT_W-1:0]   credit_q;
  logic                  stall_rs1;
  logic                  stall_rs2;
  logic                  stall_rd;

  assign opcode    = opcode_e'(instr_i[6:0]);
  assign funct3    = instr_i[14:12];
  assign funct7    = instr_i[31:25];
  assign rd        = instr_i[11:7];
  assign raddr_a_o = instr_i[19:15];
  assign raddr_b_o = instr_i[24:20];

  // Sign extended I-type, zero extended shift amount, U-type upper bits
  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_shamt  = {27'b0, instr_i[24:20]};
  assign imm_u_type = {instr_i[31:12], 12'b0};

  ////////////////////////////////////////////////////////////////////////////
  // Opcode and function decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    // funct3 maps straight onto the first eight ALU codes
    alu_op   = alu_op_e'({1'b0, funct3});
    imm_b    = imm_i_type;
    use_imm  = 1'b0;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    illegal  = 1'b0;
    case (opcode)
      OPC_OP:
      begin
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        // Alternate encoding only for SUB and SRA
        if (funct7 == 7'b0100000)
        begin
          if (funct3 == 3'b000)
            alu_op = ALU_SUB;
          else if (funct3 == 3'b101)
            alu_op = ALU_SRA;
          else
            illegal = 1'b1;
        end
        else if (funct7 != 7'b0000000)
        begin
          illegal = 1'b1;
        end
      end
      OPC_OP_IMM:
      begin
        uses_rs1 = 1'b1;
        use_imm  = 1'b1;
        // Shifts take shamt and check the upper bits
        if (funct3 == 3'b001)
        begin
          imm_b   = imm_shamt;
          illegal = (funct7 != 7'b0000000);
        end
        else if (funct3 == 3'b101)
        begin
          imm_b = imm_shamt;
          if (funct7 == 7'b0100000)
            alu_op = ALU_SRA;
          else if (funct7 != 7'b0000000)
            illegal = 1'b1;
        end
      end
      OPC_LUI:
      begin
        alu_op  = ALU_PASS_B;
        imm_b   = imm_u_type;
        use_imm = 1'b1;
      end
      default:
      begin
        illegal = 1'b1;
      end
    endcase
  end

  // Issue packet, nothing written for an illegal word
  assign pkt_o.alu_op    = alu_op;
  assign pkt_o.operand_a = rdata_a_i;
  assign pkt_o.operand_b = use_imm ? imm_b : rdata_b_i;
  assign pkt_o.rd        = rd;
  assign pkt_o.we        = !illegal;
  assign pkt_o.illegal   = illegal;

  ////////////////////////////////////////////////////////////////////////////
  // Hazards, credits and acceptance
  ////////////////////////////////////////////////////////////////////////////

  // Bit 0 never set, so x0 never stalls
  assign stall_rs1 = uses_rs1 && pending_q[raddr_a_o];
  assign stall_rs2 = uses_rs2 && pending_q[raddr_b_o];
  assign stall_rd  = !illegal && pending_q[rd];

  assign instr_ready_o = (credit_q != '0) && !stall_rs1 && !stall_rs2 && !stall_rd;
  assign push_o        = instr_valid_i && instr_ready_o;

  // Clear on write-back, set on push of a writing op
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pending_q <= '0;
    end
    else
    begin
      if (wb_i.we)
        pending_q[wb_i.addr] <= 1'b0;
      if (push_o && pkt_o.we && (rd != '0))
        pending_q[rd] <= 1'b1;
    end
  end

  // One credit per free queue slot
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      credit_q <= CREDIT_W'(QUEUE_DEPTH);
    else if (push_o && !credit_i)
      credit_q <= credit_q - 1'b1;
    else if (!push_o && credit_i)
      credit_q <= credit_q + 1'b1;
  end

endmodule

`default_nettype wire

/* rtl/register_file.sv */
// Register file of 32 x 32 bits, two combinational read ports, one write port, x0 tied to zero
`default_nettype none

module register_file
  import core_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [REG_ADDR_W-1:0] raddr_a_i,
  input  logic [REG_ADDR_W-1:0] raddr_b_i,
  output logic [XLEN-1:0]       rdata_a_o,
  output logic [XLEN-1:0]       rdata_b_o,
  input  wb_t                   wb_i
);

  // Only x1..x31 have storage
  logic [XLEN-1:0] regs_q [1:NUM_REGS-1];

  // Write port, x0 writes dropped
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 1; i < NUM_REGS; i++)
      begin
        regs_q[i] <= '0;
      end
    end
    else if (wb_i.we && (wb_i.addr != '0))
    begin
      regs_q[wb_i.addr] <= wb_i.data;
    end
  end

  // Read ports, x0 reads as zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

`default_nettype wire

/* rtl/core_pkg.sv */
// Shared widths, queue sizing, opcode and ALU enums, and packet structs for the issue path
`default_nettype none

package core_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and sizes
  ////////////////////////////////////////////////////////////////////////////

  // Integer data path
  localparam int XLEN       = 32;
  // Architectural registers, x0 included
  localparam int NUM_REGS   = 32;
  localparam int REG_ADDR_W = 5;

  // Issue queue entries, also the reset value of the decoder credit count
  localparam int QUEUE_DEPTH = 4;
  localparam int QUEUE_PTR_W = 2;
  // Must hold the value QUEUE_DEPTH itself
  localparam int CREDIT_W    = 3;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////

  // Major opcode field, instr[6:0]
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111
  } opcode_e;

  // ALU operation, funct3 order for the first eight
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SLL    = 4'd1,
    ALU_SLT    = 4'd2,
    ALU_SLTU   = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_SRL    = 4'd5,
    ALU_OR     = 4'd6,
    ALU_AND    = 4'd7,
    ALU_SUB    = 4'd8,
    ALU_SRA    = 4'd9,
    ALU_PASS_B = 4'd10
  } alu_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // Packets
  ////////////////////////////////////////////////////////////////////////////

  // Decoded operation, decoder to queue to ALU
  typedef struct packed {
    alu_op_e               alu_op;
    logic [XLEN-1:0]       operand_a;
    logic [XLEN-1:0]       operand_b;
    logic [REG_ADDR_W-1:0] rd;
    logic                  we;
    logic                  illegal;
  } issue_pkt_t;

  // Completed operation at the output port
  typedef struct packed {
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       value;
    logic                  illegal;
  } result_t;

  // Register file write, also clears the scoreboard
  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] addr;
    logic [XLEN-1:0]       data;
  } wb_t;

endpackage

`default_nettype wire
